/* sim.f */
hdl/i2c_pkg.sv
hdl/i2c_line_filter.sv
hdl/i2c_byte_receiver.sv
hdl/rx_fifo.sv
hdl/reg_writer.sv
hdl/i2c_slave_top.sv
sim/tb_i2c_slave.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log
rm -f sim.log
verilator --binary --timing -f sim.f --top-module tb_i2c_slave &&
obj_dir/Vtb_i2c_slave > sim.log 2>&1 &&
cat sim.log &&
! grep -q "FAIL: see errors above" sim.log &&
grep -q "PASS: all tests" sim.log ||
{ echo "Simulation failed"; exit 1; }
echo "Simulation passed"

/* sim/tb_i2c_slave.sv */
`timescale 1ns/1ps

module tb_i2c_slave import i2c_pkg::*;;

	localparam logic [3:0] ADDR_HI    = 4'b1010;
	localparam int         FIFO_DEPTH = 4;
	localparam logic [7:0] WR_ADDR    = 8'hAA; // 1010 101, write
	localparam logic [7:0] RD_ADDR    = 8'hAB; // Same slave, read

	logic              clock = 1'b0;
	logic              rst_n;
	logic              scl;
	logic              sda_in;    // Master side of the bus
	logic              sda_line;  // Wired AND of master and slave
	logic [2:0]        addr_pins;
	logic              hold;
	logic [REG_AW-1:0] rd_addr;
	logic              sda_oe;
	logic [7:0]        rd_data;

	logic [7:0] ref_regs [256]; // Reference register file
	bit         touched  [256];
	logic [7:0] ref_ptr     = 8'h00;
	logic       model_first = 1'b0; // Next accepted byte is the pointer
	logic       model_addressed = 1'b0; // Slave ACKed the address of this transfer
	int         model_cnt   = 0;    // FIFO fill, only while hold is high
	logic       cmp_req     = 1'b0; // Handshake to the compare process
	logic       cmp_done    = 1'b0;
	int         ack_errs    = 0;
	int         reg_errs    = 0;
	int         cmp_timeouts   = 0;
	int         drain_timeouts = 0;

	always #20 clock = ~clock; // 40 ns period

	assign sda_line = sda_in & ~sda_oe;

	i2c_slave_top #(.SLAVE_ADDR_HI(ADDR_HI), .FIFO_DEPTH(FIFO_DEPTH)) dut0 (
		.clock(clock), .rst_n(rst_n), .scl(scl), .sda(sda_line),
		.addr_pins(addr_pins), .hold(hold), .rd_addr(rd_addr),
		.sda_oe(sda_oe), .rd_data(rd_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model and compare tasks
	//////////////////////////////////////////////////////////////////////

	// ACK rule from the bus protocol of this slave
	function automatic logic expect_ack(input logic is_addr, input logic [7:0] b,
		input logic [2:0] pins, input logic addressed, input int fifo_cnt);
		if (is_addr) begin
			return b == {ADDR_HI, pins, 1'b0}; // Our 7-bit address, write only
		end
		return addressed && fifo_cnt < FIFO_DEPTH; // Full FIFO means NACK
	endfunction

	task automatic check_ack(input logic got, input logic exp, input string what);
		rx_state_t st;
		st = dut0.rx0.state;
		if (got !== exp) begin
			$display("Fail at %0t ns: %s ack %b, expected %b, receiver in %s",
				$time, what, got, exp, st.name());
			ack_errs++;
		end
	endtask

	task automatic check_reg(input logic [REG_AW-1:0] addr, input logic [7:0] got,
		input logic [7:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: reg %h reads %h, expected %h", $time, addr, got, exp);
			reg_errs++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus master, 8 clocks per half SCL period
	//////////////////////////////////////////////////////////////////////

	task automatic clocks(input int n);
		repeat (n) @(posedge clock);
	endtask

	task automatic send_start(); // Also a repeated START
		clocks(4);
		sda_in <= 1'b1;
		clocks(4);
		scl <= 1'b1;
		clocks(8);
		sda_in <= 1'b0; // SDA falls, SCL high
		clocks(8);
		scl <= 1'b0;
	endtask

	task automatic send_stop();
		clocks(4);
		sda_in <= 1'b0;
		clocks(4);
		scl <= 1'b1;
		clocks(8);
		sda_in <= 1'b1; // SDA rises, SCL high
		clocks(8);
		model_addressed = 1'b0; // Bus free
	endtask

	task automatic send_byte(input logic [7:0] b, output logic ack);
		for (int i = 7; i >= 0; i--) begin
			clocks(4);
			sda_in <= b[i]; // MSB first
			clocks(4);
			scl <= 1'b1;
			clocks(8);
			scl <= 1'b0;
		end
		clocks(4);
		sda_in <= 1'b1; // Release for the ninth pulse
		clocks(4);
		scl <= 1'b1;
		clocks(4);
		@(negedge clock);
		ack = ~sda_line; // Slave pulls low to ACK
		clocks(4);
		scl <= 1'b0;
	endtask

	// Send, check ACK, then apply the pointer rule to the model
	task automatic send_checked(input logic is_addr, input logic [7:0] b, input string what);
		logic exp;
		logic got;
		exp = expect_ack(is_addr, b, addr_pins, model_addressed, model_cnt);
		send_byte(b, got);
		check_ack(got, exp, what);
		if (is_addr) begin
			model_addressed = exp;
			model_first     = exp;
		end else if (exp) begin
			if (hold) model_cnt++;
			if (model_first) begin
				ref_ptr     = b;
				model_first = 1'b0;
			end else begin
				ref_regs[ref_ptr] = b;
				touched[ref_ptr]  = 1'b1;
				ref_ptr           = ref_ptr + 8'd1; // Wraps at FF
			end
		end
	endtask

	task automatic send_data(input int n);
		for (int i = 0; i < n; i++) send_checked(1'b0, 8'($urandom), "data byte");
	endtask

	// Hand the readback to the compare process and wait for it
	task automatic run_compare();
		int n;
		cmp_req = 1'b1;
		n = 0;
		while (!cmp_done && n < 2000) begin
			@(posedge clock);
			n++;
		end
		if (!cmp_done) begin
			$display("Timeout: register readback did not finish within 2000 cycles");
			cmp_timeouts++;
		end
		cmp_req = 1'b0;
		n = 0;
		while (cmp_done && n < 10) begin
			@(posedge clock);
			n++;
		end
		if (cmp_done) begin
			$display("Timeout: compare process did not clear its done flag");
			cmp_timeouts++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare process
	//////////////////////////////////////////////////////////////////////

	task automatic compare_regs();
		int         n;
		logic [7:0] idx;
		n = 0;
		while (!dut0.empty && n < 20) begin // Drain wait
			@(negedge clock);
			n++;
		end
		if (!dut0.empty) begin
			$display("Timeout: FIFO still not empty after 20 cycles at %0t ns", $time);
			drain_timeouts++;
		end
		for (int a = 0; a < 256; a++) begin
			idx = 8'(a);
			if (touched[idx]) begin
				@(posedge clock);
				rd_addr <= idx;
				@(negedge clock); // rd_data settled
				check_reg(idx, rd_data, ref_regs[idx]);
			end
		end
	endtask

	initial begin : reg_compare
		rd_addr <= '0;
		forever begin
			@(negedge clock);
			if (cmp_req && !cmp_done) begin
				compare_regs();
				cmp_done = 1'b1;
			end else if (!cmp_req) begin
				cmp_done = 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(40));
		for (int i = 0; i < 256; i++) ref_regs[i] = 8'h00; // Reset contents
		scl       <= 1'b1; // Idle bus
		sda_in    <= 1'b1;
		addr_pins <= 3'b101;
		hold      <= 1'b0;
		rst_n     <= 1'b0;
		clocks(2);
		rst_n <= 1'b1;
		clocks(4);

		// Pointer and six data bytes
		send_start();
		send_checked(1'b1, WR_ADDR, "address");
		send_checked(1'b0, 8'h10, "pointer");
		send_data(6);
		send_stop();
		run_compare();

		// Wrong upper address bits, then wrong strapping
		// Bytes aimed at the registers written above must not land
		send_start();
		send_checked(1'b1, 8'hBA, "foreign address");
		send_checked(1'b0, 8'h10, "pointer after foreign address");
		send_data(2);
		send_stop();
		addr_pins <= 3'b011;
		clocks(1);
		send_start();
		send_checked(1'b1, WR_ADDR, "address with other pins");
		send_checked(1'b0, 8'h10, "pointer after other pins");
		send_data(2);
		send_stop();
		addr_pins <= 3'b101;
		clocks(1);
		run_compare();

		// Read request is refused
		send_start();
		send_checked(1'b1, RD_ADDR, "read address");
		send_checked(1'b0, 8'h10, "pointer after read address");
		send_data(2);
		send_stop();
		run_compare();

		// Repeated START loads a new pointer
		send_start();
		send_checked(1'b1, WR_ADDR, "address");
		send_checked(1'b0, 8'h40, "pointer");
		send_data(2);
		send_start();
		send_checked(1'b1, WR_ADDR, "address after repeated start");
		send_checked(1'b0, 8'h80, "pointer");
		send_data(2);
		send_stop();
		run_compare();

		// Wrap past FF into 00
		send_start();
		send_checked(1'b1, WR_ADDR, "address");
		send_checked(1'b0, 8'hFE, "pointer");
		send_data(3);
		send_stop();
		run_compare();

		// Drain frozen, FIFO fills after four entries
		hold <= 1'b1;
		clocks(1);
		send_start();
		send_checked(1'b1, WR_ADDR, "address");
		send_checked(1'b0, 8'h20, "pointer");
		send_data(6);
		send_stop();
		hold <= 1'b0;
		clocks(1);
		model_cnt = 0; // Model FIFO drains at once
		run_compare();

		$display("Summary: %0d ack errors, %0d register errors, %0d timeouts",
			ack_errs, reg_errs, cmp_timeouts + drain_timeouts);
		if (ack_errs + reg_errs + cmp_timeouts + drain_timeouts == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* hdl/i2c_slave_top.sv */
`timescale 1ns/1ps

module i2c_slave_top import i2c_pkg::*; #(
	parameter logic [3:0] SLAVE_ADDR_HI = 4'b1010,
	parameter int         FIFO_DEPTH    = 4
) (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              scl,       // Raw bus lines
	input  logic              sda,
	input  logic [2:0]        addr_pins,
	input  logic              hold,
	input  logic [REG_AW-1:0] rd_addr,
	output logic              sda_oe,    // Open drain enable for SDA
	output logic [7:0]        rd_data
);

	logic               scl_rise;  // Filter to receiver
	logic               scl_fall;
	logic               sda_bit;
	logic               start_det;
	logic               stop_det;
	logic               push;      // Receiver to FIFO
	logic [ENTRY_W-1:0] push_data;
	logic               full;
	logic               pop;       // FIFO to register writer
	logic [ENTRY_W-1:0] pop_data;
	logic               empty;

	i2c_line_filter filt0 (
		.clock(clock), .rst_n(rst_n), .scl(scl), .sda(sda),
		.scl_rise(scl_rise), .scl_fall(scl_fall), .sda_bit(sda_bit),
		.start_det(start_det), .stop_det(stop_det)
	);

	i2c_byte_receiver #(.SLAVE_ADDR_HI(SLAVE_ADDR_HI)) rx0 (
		.clock(clock), .rst_n(rst_n),
		.scl_rise(scl_rise), .scl_fall(scl_fall), .sda_bit(sda_bit),
		.start_det(start_det), .stop_det(stop_det),
		.addr_pins(addr_pins), .full(full),
		.sda_oe(sda_oe), .push(push), .push_data(push_data)
	);

	rx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
		.clock(clock), .rst_n(rst_n),
		.push(push), .push_data(push_data), .pop(pop),
		.pop_data(pop_data), .full(full), .empty(empty)
	);

	reg_writer wr0 (
		.clock(clock), .rst_n(rst_n), .empty(empty), .pop_data(pop_data),
		.hold(hold), .rd_addr(rd_addr), .pop(pop), .rd_data(rd_data)
	);

endmodule

/* hdl/reg_writer.sv */
`timescale 1ns/1ps

module reg_writer import i2c_pkg::*; (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               empty,
	input  logic [ENTRY_W-1:0] pop_data,
	input  logic               hold,     // Host freezes the drain
	input  logic [REG_AW-1:0]  rd_addr,
	output logic               pop,
	output logic [7:0]         rd_data
);

	localparam int NREGS = 2**REG_AW;

	logic [7:0]        regs [0:NREGS-1];
	logic [REG_AW-1:0] ptr;      // Next register to write
	logic              is_ptr;   // Head entry carries the pointer
	logic [7:0]        byte_val;

	assign pop      = !empty && !hold; // One entry per clock
	assign is_ptr   = pop_data[ENTRY_W-1];
	assign byte_val = pop_data[7:0];

	//////////////////////////////////////////////////////////////////////
	// Pointer and register file
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			ptr <= '0;
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= 8'h00;
			end
		end else if (pop) begin
			if (is_ptr) begin
				ptr <= byte_val[REG_AW-1:0]; // First byte of a transfer
			end else begin
				regs[ptr] <= byte_val;
				ptr       <= ptr + 1'b1;     // Wraps at 8'hFF
			end
		end
	end

	// Host read port, no clock
	assign rd_data = regs[rd_addr];

endmodule

/* hdl/rx_fifo.sv */
`timescale 1ns/1ps

module rx_fifo import i2c_pkg::*; #(
	parameter int FIFO_DEPTH = 4 // Power of two
) (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               push,      // Never while full
	input  logic [ENTRY_W-1:0] push_data,
	input  logic               pop,       // Never while empty
	output logic [ENTRY_W-1:0] pop_data,  // Head entry
	output logic               full,
	output logic               empty
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	logic [ENTRY_W-1:0] mem [0:FIFO_DEPTH-1];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [PTR_W:0]     count;     // One extra bit for the full case

	// Entry storage
	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Pointers wrap naturally on the power of two depth
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop)  rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ; // Both or neither leaves it
			endcase
		end
	end

	assign pop_data = mem[rd_ptr];
	assign full     = (count == (PTR_W+1)'(FIFO_DEPTH));
	assign empty    = (count == '0);

endmodule

/* hdl/i2c_byte_receiver.sv */
`timescale 1ns/1ps

module i2c_byte_receiver import i2c_pkg::*; #(
	parameter logic [3:0] SLAVE_ADDR_HI = 4'b1010 // Fixed upper address bits
) (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               scl_rise,
	input  logic               scl_fall,
	input  logic               sda_bit,
	input  logic               start_det,
	input  logic               stop_det,
	input  logic [2:0]         addr_pins, // Board strapping, low address bits
	input  logic               full,
	output logic               sda_oe,    // High pulls SDA low
	output logic               push,
	output logic [ENTRY_W-1:0] push_data
);

	rx_state_t  state;
	logic [7:0] shreg;      // MSB first
	logic [3:0] bit_cnt;    // Bits taken in the current byte
	logic       first_byte; // Next pushed byte is the pointer
	logic       addr_hit;

	// Address and R/W from the shift register, write only
	assign addr_hit = (shreg[7:4] == SLAVE_ADDR_HI) &&
	                  (shreg[3:1] == addr_pins) &&
	                  !shreg[0];

	//////////////////////////////////////////////////////////////////////
	// Byte FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state      <= st_idle;
			bit_cnt    <= 4'd0;
			first_byte <= 1'b0;
			sda_oe     <= 1'b0;
			push       <= 1'b0;
		end else begin
			push <= 1'b0; // Strobe
			if (start_det) begin
				// Repeated START too, from any state
				state   <= st_addr;
				bit_cnt <= 4'd0;
				sda_oe  <= 1'b0;
			end else if (stop_det) begin
				state  <= st_idle;
				sda_oe <= 1'b0;
			end else begin
				case (state)
					st_addr, st_data: begin
						if (scl_rise && bit_cnt != 4'd8) begin
							bit_cnt <= bit_cnt + 4'd1;
						end
						// Decide on the fall after the eighth bit
						if (scl_fall && bit_cnt == 4'd8) begin
							if (state == st_addr) begin
								if (addr_hit) begin
									sda_oe     <= 1'b1;
									first_byte <= 1'b1;
									state      <= st_addr_ack;
								end else begin
									state <= st_ignore; // Not ours or a read
								end
							end else begin
								if (!full) begin
									sda_oe     <= 1'b1;
									push       <= 1'b1;
									first_byte <= 1'b0;
								end
								state <= st_data_ack; // NACK slot still clocked
							end
						end
					end
					st_addr_ack, st_data_ack: begin
						if (scl_fall) begin // End of the ninth pulse
							sda_oe  <= 1'b0;
							bit_cnt <= 4'd0;
							state   <= st_data;
						end
					end
					default: ; // Idle and ignore wait for START or STOP
				endcase
			end
		end
	end

	// Shifter and FIFO payload
	always_ff @(posedge clock) begin
		if (scl_rise && bit_cnt != 4'd8) begin
			shreg <= {shreg[6:0], sda_bit};
		end
		if (state == st_data && scl_fall && bit_cnt == 4'd8) begin
			push_data <= {first_byte, shreg};
		end
	end

endmodule

/* hdl/i2c_line_filter.sv */
`timescale 1ns/1ps

module i2c_line_filter (
	input  logic clock,
	input  logic rst_n,
	input  logic scl,       // Raw bus clock, asynchronous
	input  logic sda,       // Raw bus data, asynchronous
	output logic scl_rise,  // One clock strobes
	output logic scl_fall,
	output logic sda_bit,   // Settled SDA level, aligned with the strobes
	output logic start_det,
	output logic stop_det
);

	logic [1:0] scl_sync; // Two flop synchronizers
	logic [1:0] sda_sync;
	logic       scl_q;    // Edge stage, last settled level
	logic       sda_q;

	// Synchronizers then one edge stage, three clocks from pin to strobe
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			scl_sync  <= 2'b11; // Idle bus is high
			sda_sync  <= 2'b11;
			scl_q     <= 1'b1;
			sda_q     <= 1'b1;
			scl_rise  <= 1'b0;
			scl_fall  <= 1'b0;
			start_det <= 1'b0;
			stop_det  <= 1'b0;
		end else begin
			scl_sync <= {scl_sync[0], scl};
			sda_sync <= {sda_sync[0], sda};
			scl_q    <= scl_sync[1];
			sda_q    <= sda_sync[1];

			scl_rise <= scl_sync[1] & ~scl_q;
			scl_fall <= ~scl_sync[1] & scl_q;

			// SDA moving while SCL stays high
			start_det <= scl_sync[1] & scl_q & sda_q & ~sda_sync[1];
			stop_det  <= scl_sync[1] & scl_q & ~sda_q & sda_sync[1];
		end
	end

	assign sda_bit = sda_q; // Same stage as the strobes

endmodule

/* hdl/i2c_pkg.sv */
package i2c_pkg;

	//////////////////////////////////////////////////////////////////////
	// Receiver FSM states
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		st_idle     = 3'd0, // Bus free or not for us
		st_addr     = 3'd1, // Shifting in address and R/W
		st_addr_ack = 3'd2, // Driving ACK for our address
		st_data     = 3'd3, // Shifting in a data byte
		st_data_ack = 3'd4, // ACK or NACK slot of a data byte
		st_ignore   = 3'd5  // Someone else's transfer, wait for START or STOP
	} rx_state_t;

	//////////////////////////////////////////////////////////////////////
	// Widths shared between blocks
	//////////////////////////////////////////////////////////////////////

	// Register file address, 256 bytes
	localparam int REG_AW = 8;

	// FIFO entry layout
	// [8]   first byte after the address, loads the pointer
	// [7:0] received byte
	localparam int ENTRY_W = 9;

endpackage
